// ==== source/i3c_ibi_pkg.sv ====
// IBI protocol types: status codes, sequencer states, bit-engine opcodes, field widths
package i3c_ibi_pkg;

  // Retry limit and counter width, all ones means unlimited
  localparam int unsigned RETRY_W = 3;
  localparam int unsigned ADDR_W  = 7;

  typedef enum logic [1:0] {
    IbiSuccess            = 2'b00,
    IbiFailureNack        = 2'b01,
    IbiFailurePartialData = 2'b10,
    IbiFailureRetry       = 2'b11
  } ibi_status_e;

  typedef enum logic [3:0] {
    Idle,
    WaitAvail,
    DriveStart,
    DriveAddr,
    ReadAck,
    SendData,
    SendTbit,
    WaitStop,
    Flush,
    Done
  } ibi_state_e;

  typedef enum logic [1:0] {
    OpNone,
    OpTxByte,
    OpTxBit,
    OpRxBit
  } bit_op_e;

endpackage

// ==== source/i3c_timing_pkg.sv ====
// Sizing and timing constants: counter widths, queue depth, bus-free time
package i3c_timing_pkg;

  // Data hold time counter width
  localparam int unsigned THD_W = 20;

  localparam int unsigned QUEUE_DEPTH = 8;
  localparam int unsigned QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
  localparam int unsigned QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

  // Both lines high this long before the bus counts as free
  localparam int unsigned BUS_AVAIL_CYCLES = 16;
  localparam int unsigned BUS_AVAIL_W      = $clog2(BUS_AVAIL_CYCLES + 1);

endpackage

// ==== source/ibi_queue.sv ====
// IBI byte queue: circular buffer of data bytes with a last flag
`timescale 1ns/1ps

module ibi_queue (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       wvalid_i,
  input  logic [7:0] wdata_i,
  input  logic       wlast_i,
  output logic       wready_o,
  output logic       rvalid_o,
  output logic [7:0] rdata_o,
  output logic       rlast_o,
  input  logic       rready_i
);

  // Entry layout is {last, data}
  logic [8:0] mem_q [i3c_timing_pkg::QUEUE_DEPTH];

  logic [i3c_timing_pkg::QUEUE_PTR_W-1:0] wr_ptr_q;
  logic [i3c_timing_pkg::QUEUE_PTR_W-1:0] rd_ptr_q;
  logic [i3c_timing_pkg::QUEUE_CNT_W-1:0] count_q;
  logic                                   push;
  logic                                   pop;

  assign wready_o = (count_q != i3c_timing_pkg::QUEUE_CNT_W'(i3c_timing_pkg::QUEUE_DEPTH));
  assign rvalid_o = (count_q != '0);
  assign push     = wvalid_i & wready_o;
  assign pop      = rready_i & rvalid_o;

  // Head entry shown combinationally
  assign {rlast_o, rdata_o} = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= {wlast_i, wdata_i};
    end
  end

  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// ==== source/bus_monitor.sv ====
// Bus monitor: SCL edges, START, STOP and bus-free detection from sampled lines
`timescale 1ns/1ps

module bus_monitor (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic scl_i,
  input  logic sda_i,
  output logic scl_negedge_o,
  output logic scl_posedge_o,
  output logic bus_stop_o,
  output logic bus_available_o
);

  // Two sync stages plus one previous-value stage per line
  logic [2:0] scl_sync_q;
  logic [2:0] sda_sync_q;
  logic       bus_start;
  logic       idle_clear;

  logic [i3c_timing_pkg::BUS_AVAIL_W-1:0] idle_cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_sync_q <= '1;
      sda_sync_q <= '1;
    end else begin
      scl_sync_q <= {scl_sync_q[1:0], scl_i};
      sda_sync_q <= {sda_sync_q[1:0], sda_i};
    end
  end

  assign scl_negedge_o = scl_sync_q[2] & ~scl_sync_q[1];
  assign scl_posedge_o = ~scl_sync_q[2] & scl_sync_q[1];

  // SDA moving while SCL stays high
  assign bus_stop_o = scl_sync_q[2] & scl_sync_q[1] & ~sda_sync_q[2] & sda_sync_q[1];
  assign bus_start  = scl_sync_q[2] & scl_sync_q[1] & sda_sync_q[2] & ~sda_sync_q[1];

  // Any low line, any change or a START restarts the idle count
  assign idle_clear = ~scl_sync_q[1] | ~sda_sync_q[1] | bus_start |
                      (scl_sync_q[2] ^ scl_sync_q[1]) | (sda_sync_q[2] ^ sda_sync_q[1]);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idle_cnt_q <= '0;
    end else if (idle_clear) begin
      idle_cnt_q <= '0;
    end else if (!bus_available_o) begin
      idle_cnt_q <= idle_cnt_q + 1'b1;
    end
  end

  assign bus_available_o =
    (idle_cnt_q == i3c_timing_pkg::BUS_AVAIL_W'(i3c_timing_pkg::BUS_AVAIL_CYCLES));

endmodule

// ==== source/ibi_fsm.sv ====
// IBI sequencer: start, address, ACK, data with T bits, retry counting and status
`timescale 1ns/1ps

module ibi_fsm (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  begin_i,
  output logic                                  done_o,
  output i3c_ibi_pkg::ibi_status_e              status_o,
  input  logic [i3c_ibi_pkg::RETRY_W-1:0]       retry_num_i,
  input  logic [i3c_ibi_pkg::ADDR_W-1:0]        addr_i,
  input  logic                                  addr_valid_i,
  input  logic [i3c_timing_pkg::THD_W-1:0]      t_hd_dat_i,
  input  logic                                  byte_valid_i,
  input  logic [7:0]                            byte_data_i,
  input  logic                                  byte_last_i,
  output logic                                  byte_ready_o,
  input  logic                                  scl_negedge_i,
  input  logic                                  bus_stop_i,
  input  logic                                  bus_available_i,
  output i3c_ibi_pkg::bit_op_e                  op_o,
  output logic [7:0]                            tx_value_o,
  output logic                                  pp_o,
  input  logic                                  op_done_i,
  input  logic                                  rx_bit_i,
  output logic                                  start_pull_o
);

  i3c_ibi_pkg::ibi_state_e  state_q;
  i3c_ibi_pkg::ibi_state_e  state_d;
  i3c_ibi_pkg::ibi_status_e status_q;
  i3c_ibi_pkg::ibi_status_e nack_status;

  logic [i3c_ibi_pkg::RETRY_W-1:0]  retry_cnt_q;
  logic [i3c_ibi_pkg::RETRY_W-1:0]  retry_cnt_inc;
  logic [i3c_timing_pkg::THD_W-1:0] hold_cnt_q;
  logic                             hold_run_q;
  logic                             can_attempt;
  logic                             start_release;
  logic                             before_data;

  assign can_attempt = (retry_num_i == '1) || (retry_cnt_q < retry_num_i);

  // Saturate so unlimited retries never wrap to zero
  assign retry_cnt_inc = (retry_cnt_q == '1) ? retry_cnt_q : retry_cnt_q + 1'b1;
  assign nack_status   = (retry_cnt_q == '0) ? i3c_ibi_pkg::IbiFailureNack
                                             : i3c_ibi_pkg::IbiFailureRetry;

  // SDA released one hold time after the first SCL fall
  assign start_release = (scl_negedge_i && t_hd_dat_i == '0) ||
                         (hold_run_q && hold_cnt_q == '0);

  assign before_data = (state_q == i3c_ibi_pkg::WaitAvail)  ||
                       (state_q == i3c_ibi_pkg::DriveStart) ||
                       (state_q == i3c_ibi_pkg::DriveAddr)  ||
                       (state_q == i3c_ibi_pkg::ReadAck);

  always_comb begin
    state_d = state_q;
    case (state_q)
      i3c_ibi_pkg::Idle:
        if (begin_i && addr_valid_i) begin
          state_d = can_attempt ? i3c_ibi_pkg::WaitAvail : i3c_ibi_pkg::Flush;
        end
      i3c_ibi_pkg::WaitAvail:
        if (bus_stop_i) state_d = i3c_ibi_pkg::Done;
        else if (bus_available_i) state_d = i3c_ibi_pkg::DriveStart;
      i3c_ibi_pkg::DriveStart:
        if (bus_stop_i) state_d = i3c_ibi_pkg::Done;
        else if (start_release) state_d = i3c_ibi_pkg::DriveAddr;
      i3c_ibi_pkg::DriveAddr:
        if (bus_stop_i) state_d = i3c_ibi_pkg::Done;
        else if (op_done_i) state_d = i3c_ibi_pkg::ReadAck;
      i3c_ibi_pkg::ReadAck:
        if (bus_stop_i) state_d = i3c_ibi_pkg::Done;
        else if (op_done_i) state_d = rx_bit_i ? i3c_ibi_pkg::WaitStop : i3c_ibi_pkg::SendData;
      i3c_ibi_pkg::SendData:
        if (bus_stop_i) state_d = i3c_ibi_pkg::Flush;
        else if (op_done_i) state_d = i3c_ibi_pkg::SendTbit;
      i3c_ibi_pkg::SendTbit:
        if (bus_stop_i) state_d = i3c_ibi_pkg::Flush;
        else if (op_done_i) state_d = byte_last_i ? i3c_ibi_pkg::Done : i3c_ibi_pkg::SendData;
      i3c_ibi_pkg::WaitStop:
        if (bus_stop_i) state_d = i3c_ibi_pkg::Done;
      i3c_ibi_pkg::Flush:
        if (!byte_valid_i) state_d = i3c_ibi_pkg::Done;
      default: state_d = i3c_ibi_pkg::Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= i3c_ibi_pkg::Idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_run_q <= 1'b0;
      hold_cnt_q <= '0;
    end else if (state_q != i3c_ibi_pkg::DriveStart) begin
      hold_run_q <= 1'b0;
    end else if (scl_negedge_i && !hold_run_q) begin
      hold_run_q <= 1'b1;
      hold_cnt_q <= t_hd_dat_i - 1'b1;
    end else if (hold_run_q && hold_cnt_q != '0) begin
      hold_cnt_q <= hold_cnt_q - 1'b1;
    end
  end

  // Outcome of each attempt, settled before Done
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      status_q    <= i3c_ibi_pkg::IbiSuccess;
      retry_cnt_q <= '0;
    end else if (state_q == i3c_ibi_pkg::Idle && begin_i && addr_valid_i && !can_attempt) begin
      status_q    <= i3c_ibi_pkg::IbiFailureRetry;
      retry_cnt_q <= '0;
    end else if ((before_data && bus_stop_i) ||
                 (state_q == i3c_ibi_pkg::ReadAck && op_done_i && rx_bit_i)) begin
      // Unacknowledged attempt
      status_q    <= nack_status;
      retry_cnt_q <= retry_cnt_inc;
    end else if ((state_q == i3c_ibi_pkg::SendData || state_q == i3c_ibi_pkg::SendTbit) &&
                 bus_stop_i) begin
      status_q    <= i3c_ibi_pkg::IbiFailurePartialData;
      retry_cnt_q <= '0;
    end else if (state_q == i3c_ibi_pkg::SendTbit && op_done_i && byte_last_i) begin
      status_q    <= i3c_ibi_pkg::IbiSuccess;
      retry_cnt_q <= '0;
    end
  end

  always_comb begin
    op_o       = i3c_ibi_pkg::OpNone;
    tx_value_o = '0;
    pp_o       = 1'b0;
    case (state_q)
      i3c_ibi_pkg::DriveAddr: begin
        op_o       = i3c_ibi_pkg::OpTxByte;
        tx_value_o = {addr_i, 1'b0};
      end
      i3c_ibi_pkg::ReadAck: op_o = i3c_ibi_pkg::OpRxBit;
      i3c_ibi_pkg::SendData: begin
        // Hold off the engine while the queue is empty
        op_o       = byte_valid_i ? i3c_ibi_pkg::OpTxByte : i3c_ibi_pkg::OpNone;
        tx_value_o = byte_data_i;
        pp_o       = 1'b1;
      end
      i3c_ibi_pkg::SendTbit: begin
        op_o       = i3c_ibi_pkg::OpTxBit;
        tx_value_o = {7'b0, ~byte_last_i};
        pp_o       = 1'b1;
      end
      default: op_o = i3c_ibi_pkg::OpNone;
    endcase
  end

  assign byte_ready_o = (state_q == i3c_ibi_pkg::Flush) ||
                        (state_q == i3c_ibi_pkg::SendTbit && op_done_i && !bus_stop_i);

  assign start_pull_o = (state_q == i3c_ibi_pkg::DriveStart);
  assign done_o       = (state_q == i3c_ibi_pkg::Done);
  assign status_o     = status_q;

endmodule

// ==== source/bus_bit_engine.sv ====
// Bit engine: shifts bytes or single bits onto SDA and samples the ACK bit
`timescale 1ns/1ps

module bus_bit_engine (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  i3c_ibi_pkg::bit_op_e op_i,
  input  logic [7:0]           value_i,
  input  logic                 scl_negedge_i,
  input  logic                 scl_posedge_i,
  input  logic                 sda_i,
  output logic                 done_o,
  output logic                 rx_bit_o,
  output logic                 sda_o
);

  logic       busy_q;
  logic       wait_neg_q;
  logic       rx_mode_q;
  logic       scl_high_q;
  logic       sda_q;
  logic       sda_smp_q;
  logic [7:0] shift_q;
  logic [3:0] bit_cnt_q;
  logic [7:0] load_value;
  logic       scl_low;

  // Single bit goes out of the MSB like a byte
  assign load_value = (op_i == i3c_ibi_pkg::OpTxBit) ? {value_i[0], 7'b0} : value_i;
  assign scl_low    = scl_negedge_i | ~scl_high_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q     <= 1'b0;
      wait_neg_q <= 1'b0;
      rx_mode_q  <= 1'b0;
      scl_high_q <= 1'b1;
      sda_q      <= 1'b1;
      sda_smp_q  <= 1'b1;
      shift_q    <= '0;
      bit_cnt_q  <= '0;
    end else begin
      sda_smp_q <= sda_i;
      if (scl_posedge_i) scl_high_q <= 1'b1;
      else if (scl_negedge_i) scl_high_q <= 1'b0;

      if (op_i == i3c_ibi_pkg::OpNone) begin
        busy_q     <= 1'b0;
        wait_neg_q <= 1'b0;
        sda_q      <= 1'b1;
      end else if (!busy_q) begin
        busy_q    <= 1'b1;
        rx_mode_q <= (op_i == i3c_ibi_pkg::OpRxBit);
        bit_cnt_q <= (op_i == i3c_ibi_pkg::OpTxByte) ? 4'd8 : 4'd1;
        if (op_i == i3c_ibi_pkg::OpRxBit) begin
          wait_neg_q <= 1'b0;
          sda_q      <= 1'b1;
        end else if (scl_low) begin
          // SCL already low, first bit goes out now
          wait_neg_q <= 1'b0;
          sda_q      <= load_value[7];
          shift_q    <= {load_value[6:0], 1'b0};
        end else begin
          wait_neg_q <= 1'b1;
          sda_q      <= 1'b1;
          shift_q    <= load_value;
        end
      end else if (rx_mode_q) begin
        if (scl_posedge_i) busy_q <= 1'b0;
      end else if (scl_negedge_i) begin
        if (wait_neg_q) begin
          wait_neg_q <= 1'b0;
          sda_q      <= shift_q[7];
          shift_q    <= {shift_q[6:0], 1'b0};
        end else if (bit_cnt_q == 4'd1) begin
          busy_q <= 1'b0;
        end else begin
          sda_q     <= shift_q[7];
          shift_q   <= {shift_q[6:0], 1'b0};
          bit_cnt_q <= bit_cnt_q - 1'b1;
        end
      end
    end
  end

  assign done_o = busy_q & (rx_mode_q ? scl_posedge_i
                                      : (scl_negedge_i & ~wait_neg_q & (bit_cnt_q == 4'd1)));
  assign rx_bit_o = sda_smp_q;
  assign sda_o    = sda_q;

endmodule

// ==== source/i3c_ibi_top.sv ====
// IBI top level: byte queue, bus monitor, sequencer and bit engine
`timescale 1ns/1ps

module i3c_ibi_top (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             ibi_wvalid_i,
  input  logic [7:0]                       ibi_wdata_i,
  input  logic                             ibi_wlast_i,
  output logic                             ibi_wready_o,
  input  logic                             begin_i,
  output logic                             done_o,
  output i3c_ibi_pkg::ibi_status_e         ibi_status_o,
  input  logic [i3c_ibi_pkg::RETRY_W-1:0]  ibi_retry_num_i,
  input  logic [i3c_ibi_pkg::ADDR_W-1:0]   target_addr_i,
  input  logic                             target_addr_valid_i,
  input  logic [i3c_timing_pkg::THD_W-1:0] t_hd_dat_i,
  input  logic                             scl_i,
  input  logic                             sda_i,
  output logic                             sda_o,
  output logic                             sda_pp_o
);

  logic                 byte_valid;
  logic [7:0]           byte_data;
  logic                 byte_last;
  logic                 byte_ready;
  logic                 scl_negedge;
  logic                 scl_posedge;
  logic                 bus_stop;
  logic                 bus_available;
  i3c_ibi_pkg::bit_op_e bit_op;
  logic [7:0]           tx_value;
  logic                 op_done;
  logic                 rx_bit;
  logic                 start_pull;
  logic                 engine_sda;

  ibi_queue u_queue (
    .clk_i, .rst_ni,
    .wvalid_i (ibi_wvalid_i), .wdata_i (ibi_wdata_i), .wlast_i (ibi_wlast_i),
    .wready_o (ibi_wready_o),
    .rvalid_o (byte_valid), .rdata_o (byte_data), .rlast_o (byte_last),
    .rready_i (byte_ready)
  );

  bus_monitor u_monitor (
    .clk_i, .rst_ni, .scl_i, .sda_i,
    .scl_negedge_o (scl_negedge), .scl_posedge_o (scl_posedge),
    .bus_stop_o (bus_stop), .bus_available_o (bus_available)
  );

  ibi_fsm u_fsm (
    .clk_i, .rst_ni, .begin_i, .done_o, .status_o (ibi_status_o),
    .retry_num_i (ibi_retry_num_i), .addr_i (target_addr_i),
    .addr_valid_i (target_addr_valid_i), .t_hd_dat_i,
    .byte_valid_i (byte_valid), .byte_data_i (byte_data), .byte_last_i (byte_last),
    .byte_ready_o (byte_ready),
    .scl_negedge_i (scl_negedge), .bus_stop_i (bus_stop), .bus_available_i (bus_available),
    .op_o (bit_op), .tx_value_o (tx_value), .pp_o (sda_pp_o),
    .op_done_i (op_done), .rx_bit_i (rx_bit), .start_pull_o (start_pull)
  );

  bus_bit_engine u_engine (
    .clk_i, .rst_ni, .op_i (bit_op), .value_i (tx_value),
    .scl_negedge_i (scl_negedge), .scl_posedge_i (scl_posedge), .sda_i,
    .done_o (op_done), .rx_bit_o (rx_bit), .sda_o (engine_sda)
  );

  // Wired-AND of the start pull and the engine drive
  assign sda_o = engine_sda & ~start_pull;

endmodule

// ==== testbench/i3c_ibi_sva.sv ====
// Bound assertions on the IBI sequencer for done width, start pull entry and opcode hold
`timescale 1ns/1ps

module i3c_ibi_sva (
  input logic                    clk_i,
  input logic                    rst_ni,
  input logic                    done_o,
  input logic                    start_pull_o,
  input logic                    bus_stop_i,
  input logic                    bus_available_i,
  input logic                    op_done_i,
  input i3c_ibi_pkg::ibi_state_e state_q,
  input i3c_ibi_pkg::bit_op_e    op_o
);

  // Failed assertion count that the testbench reads at the end
  int unsigned fail_count = 0;

  done_single: assert property (@(posedge clk_i) disable iff (!rst_ni) done_o |=> !done_o)
    else begin
      $error("done_o stayed high for two cycles");
      fail_count++;
    end

  // START forced only out of WaitAvail on a free bus
  start_on_free_bus: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(start_pull_o) |-> $past(state_q == i3c_ibi_pkg::WaitAvail && bus_available_i))
    else begin
      $error("start pull began without a free bus");
      fail_count++;
    end

  // A STOP may cut an operation short
  op_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (op_o != i3c_ibi_pkg::OpNone && !op_done_i && !bus_stop_i) |=> (op_o == $past(op_o)))
    else begin
      $error("bit-engine opcode changed before op_done");
      fail_count++;
    end

endmodule

bind ibi_fsm i3c_ibi_sva u_sva (
  .clk_i, .rst_ni, .done_o, .start_pull_o, .bus_stop_i, .bus_available_i, .op_done_i,
  .state_q, .op_o
);

// ==== testbench/i3c_ibi_tb.sv ====
// Testbench for the IBI top level with controller model, stimulus table, checks and watchdog
`timescale 1ns/1ps

module i3c_ibi_tb;

  localparam int HALF        = 12;
  localparam int BIT_CYCLES  = 2 * HALF;
  localparam int START_WAIT  = 200;
  localparam int DONE_WAIT   = 400;
  localparam int IDLE_WINDOW = 300;
  localparam int ROW_GAP     = 20;
  localparam int NUM_ROWS    = 13;
  // Address, ACK and a full queue of bytes with T bits, plus a STOP
  localparam int ROW_CYCLES  = (9 * (i3c_timing_pkg::QUEUE_DEPTH + 1) + 4) * BIT_CYCLES +
                               START_WAIT + DONE_WAIT + ROW_GAP;
  localparam int WATCHDOG_CYCLES = NUM_ROWS * ROW_CYCLES + 20;

  typedef struct {
    string                            name;
    logic [i3c_ibi_pkg::ADDR_W-1:0]   addr;
    logic                             addr_valid;
    logic [i3c_ibi_pkg::RETRY_W-1:0]  retry;
    int                               nbytes;
    logic                             ack;
    int                               stop_at;
    i3c_ibi_pkg::ibi_status_e         status;
  } row_t;

  // Name, address, valid, retry limit, new bytes, ACK, STOP after byte, status
  row_t rows [NUM_ROWS] = '{
    '{"ack_three",        7'h2A, 1'b1, 3'd2, 3, 1'b1, 0, i3c_ibi_pkg::IbiSuccess},
    '{"nack_first",       7'h2A, 1'b1, 3'd2, 2, 1'b0, 0, i3c_ibi_pkg::IbiFailureNack},
    '{"nack_retry",       7'h2A, 1'b1, 3'd2, 0, 1'b0, 0, i3c_ibi_pkg::IbiFailureRetry},
    '{"retry_exhausted",  7'h2A, 1'b1, 3'd2, 0, 1'b0, 0, i3c_ibi_pkg::IbiFailureRetry},
    '{"partial_stop",     7'h15, 1'b1, 3'd3, 8, 1'b1, 1, i3c_ibi_pkg::IbiFailurePartialData},
    '{"fresh_after_stop", 7'h15, 1'b1, 3'd3, 2, 1'b1, 0, i3c_ibi_pkg::IbiSuccess},
    '{"addr_invalid",     7'h33, 1'b0, 3'd3, 0, 1'b0, 0, i3c_ibi_pkg::IbiSuccess},
    '{"unlim_nack_a",     7'h5C, 1'b1, 3'd7, 1, 1'b0, 0, i3c_ibi_pkg::IbiFailureNack},
    '{"unlim_nack_b",     7'h5C, 1'b1, 3'd7, 0, 1'b0, 0, i3c_ibi_pkg::IbiFailureRetry},
    '{"unlim_nack_c",     7'h5C, 1'b1, 3'd7, 0, 1'b0, 0, i3c_ibi_pkg::IbiFailureRetry},
    '{"unlim_nack_d",     7'h5C, 1'b1, 3'd7, 0, 1'b0, 0, i3c_ibi_pkg::IbiFailureRetry},
    '{"unlim_ack",        7'h5C, 1'b1, 3'd7, 0, 1'b1, 0, i3c_ibi_pkg::IbiSuccess},
    '{"count_cleared",    7'h5C, 1'b1, 3'd1, 0, 1'b0, 0, i3c_ibi_pkg::IbiFailureNack}
  };

  logic                             clk_i;
  logic                             rst_ni;
  logic                             ibi_wvalid_i;
  logic [7:0]                       ibi_wdata_i;
  logic                             ibi_wlast_i;
  logic                             ibi_wready_o;
  logic                             begin_i;
  logic                             done_o;
  i3c_ibi_pkg::ibi_status_e         ibi_status_o;
  logic [i3c_ibi_pkg::RETRY_W-1:0]  ibi_retry_num_i;
  logic [i3c_ibi_pkg::ADDR_W-1:0]   target_addr_i;
  logic                             target_addr_valid_i;
  logic [i3c_timing_pkg::THD_W-1:0] t_hd_dat_i;
  logic                             scl_i;
  logic                             sda_i;
  logic                             sda_o;
  logic                             sda_pp_o;
  logic                             ctrl_sda;

  logic [31:0]                      lcg_state;
  logic [8:0]                       expect_q [$];
  logic [i3c_ibi_pkg::RETRY_W-1:0]  nack_model;
  int unsigned                      done_count;
  int unsigned                      sda_activity;
  i3c_ibi_pkg::ibi_status_e         done_status;

  i3c_ibi_top i3c_ibi_top_i (.*);

  // Controller and target both pull against a released line
  assign sda_i = sda_o & ctrl_sda;

  always #5 clk_i = ~clk_i;

  always @(negedge clk_i) begin
    if (done_o) begin
      done_count  = done_count + 1;
      done_status = ibi_status_o;
    end
    if (!sda_o || sda_pp_o) begin
      sda_activity = sda_activity + 1;
    end
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "run stopped on a failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Error: %s expected %0h actual %0h", name, expected, actual);
      $display("RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_i);
    #1;
  endtask

  task automatic push_byte(input logic [7:0] data, input logic last);
    int n;
    n = 0;
    while (!ibi_wready_o) begin
      wait_cycles(1);
      n++;
      if (n > 100) abort_run("The queue never became ready for a write");
    end
    ibi_wvalid_i = 1'b1;
    ibi_wdata_i  = data;
    ibi_wlast_i  = last;
    wait_cycles(1);
    ibi_wvalid_i = 1'b0;
  endtask

  task automatic load_payload(input int count);
    logic [7:0] data;
    for (int b = 0; b < count; b++) begin
      lcg_state = lcg_step(lcg_state);
      data = lcg_state[23:16];
      push_byte(data, b == count - 1);
      expect_q.push_back({b == count - 1, data});
    end
  endtask

  // One SCL period with the low half first and SDA sampled mid high
  task automatic clock_bit(input logic drive, output logic seen);
    scl_i = 1'b0;
    wait_cycles(1);
    ctrl_sda = drive;
    wait_cycles(HALF - 1);
    scl_i = 1'b1;
    wait_cycles(HALF / 2);
    seen = sda_i;
    wait_cycles(HALF - HALF / 2);
  endtask

  task automatic clock_byte(output logic [7:0] value);
    logic b;
    for (int i = 7; i >= 0; i--) begin
      clock_bit(1'b1, b);
      value[i] = b;
    end
  endtask

  task automatic stop_bus();
    scl_i = 1'b0;
    wait_cycles(HALF);
    ctrl_sda = 1'b0;
    wait_cycles(HALF);
    scl_i = 1'b1;
    wait_cycles(HALF);
    ctrl_sda = 1'b1;
    wait_cycles(HALF);
  endtask

  task automatic wait_done(input string name, input int unsigned target);
    int n;
    n = 0;
    while (done_count < target) begin
      wait_cycles(1);
      n++;
      if (n > DONE_WAIT) abort_run($sformatf("Timeout: no done pulse in test %s", name));
    end
  endtask

  // Controller side of one attempt from START to STOP
  task automatic run_attempt(input row_t row);
    logic [7:0] value;
    logic       seen;
    logic [8:0] entry;
    int         sent;
    int         n;
    logic       finished;
    n = 0;
    while (sda_i) begin
      wait_cycles(1);
      n++;
      if (n > START_WAIT) begin
        abort_run($sformatf("Timeout: no START from target in test %s", row.name));
      end
    end
    wait_cycles(4);
    clock_byte(value);
    check_value($sformatf("%s address", row.name), {row.addr, 1'b0}, value);
    check_value($sformatf("%s address push-pull", row.name), 0, sda_pp_o);
    clock_bit(~row.ack, seen);
    if (!row.ack) begin
      nack_model = (nack_model == '1) ? nack_model : nack_model + 1'b1;
      stop_bus();
    end else begin
      nack_model = '0;
      sent       = 0;
      finished   = 1'b0;
      while (!finished) begin
        if (expect_q.size() == 0) abort_run($sformatf("No payload left in test %s", row.name));
        entry = expect_q.pop_front();
        clock_byte(value);
        check_value($sformatf("%s data %0d", row.name, sent), entry[7:0], value);
        check_value($sformatf("%s data %0d push-pull", row.name, sent), 1, sda_pp_o);
        clock_bit(1'b1, seen);
        check_value($sformatf("%s T bit %0d", row.name, sent), !entry[8], seen);
        sent++;
        if (entry[8]) begin
          stop_bus();
          finished = 1'b1;
        end else if (sent == row.stop_at) begin
          // Repeated START then STOP while the T bit holds SDA high
          ctrl_sda = 1'b0;
          wait_cycles(4);
          ctrl_sda = 1'b1;
          wait_cycles(HALF);
          expect_q.delete();
          finished = 1'b1;
        end
      end
    end
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    int unsigned done_seen;
    int unsigned act_seen;
    logic        attempt;
    clk_i               = 1'b0;
    rst_ni              = 1'b0;
    ibi_wvalid_i        = 1'b0;
    ibi_wdata_i         = '0;
    ibi_wlast_i         = 1'b0;
    begin_i             = 1'b0;
    ibi_retry_num_i     = '0;
    target_addr_i       = '0;
    target_addr_valid_i = 1'b0;
    t_hd_dat_i          = 20'd2;
    scl_i               = 1'b1;
    ctrl_sda            = 1'b1;
    lcg_state           = 32'd81736;
    nack_model          = '0;
    done_count          = 0;
    sda_activity        = 0;
    done_status         = i3c_ibi_pkg::IbiSuccess;
    wait_cycles(5);
    rst_ni = 1'b1;
    wait_cycles(2);

    for (int r = 0; r < NUM_ROWS; r++) begin
      load_payload(rows[r].nbytes);
      target_addr_i       = rows[r].addr;
      target_addr_valid_i = rows[r].addr_valid;
      ibi_retry_num_i     = rows[r].retry;
      done_seen           = done_count;
      act_seen            = sda_activity;
      attempt = (rows[r].retry == '1) || (nack_model < rows[r].retry);
      begin_i = 1'b1;
      wait_cycles(1);
      begin_i = 1'b0;
      if (!rows[r].addr_valid) begin
        wait_cycles(IDLE_WINDOW);
        check_value($sformatf("%s done count", rows[r].name), done_seen, done_count);
        check_value($sformatf("%s SDA activity", rows[r].name), act_seen, sda_activity);
      end else begin
        if (attempt) begin
          run_attempt(rows[r]);
        end else begin
          // Retries used up so the queue drains without a transfer
          expect_q.delete();
          nack_model = '0;
        end
        wait_done(rows[r].name, done_seen + 1);
        wait_cycles(2);
        check_value($sformatf("%s done count", rows[r].name), done_seen + 1, done_count);
        check_value($sformatf("%s status", rows[r].name), rows[r].status, done_status);
        if (!attempt) begin
          check_value($sformatf("%s SDA activity", rows[r].name), act_seen, sda_activity);
        end
        if (rows[r].stop_at != 0) begin
          check_value($sformatf("%s write ready", rows[r].name), 1, ibi_wready_o);
        end
      end
      wait_cycles(ROW_GAP);
    end

    if (i3c_ibi_top_i.u_fsm.u_sva.fail_count == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("Assertion failures were reported during the run");
      $display("RESULT: FAIL");
      $fatal(1, "assertion failures");
    end
  end

endmodule

// ==== i3c_ibi_top.f ====
source/i3c_ibi_pkg.sv
source/i3c_timing_pkg.sv
source/ibi_queue.sv
source/bus_monitor.sv
source/ibi_fsm.sv
source/bus_bit_engine.sv
source/i3c_ibi_top.sv
testbench/i3c_ibi_sva.sv
testbench/i3c_ibi_tb.sv
